// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := flr_mux_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== design/flr_mux.sv ====
// FLR distributor top, routes host FLR requests to agents and merges agent responses back
`timescale 1ns/1ps
`include "flr_mux_defines.svh"

module flr_mux #(
   parameter flr_mux_pkg::rtable_t RTABLE = flr_mux_pkg::DEFAULT_RTABLE
) (
   input  logic                  clk,
   input  logic                  arst_n,
   input  flr_mux_pkg::flr_msg_t h_flr_req,
   output flr_mux_pkg::flr_msg_t h_flr_rsp,
   output flr_mux_pkg::flr_msg_t a_flr_req [`FLR_NUM_PORT],
   input  flr_mux_pkg::flr_msg_t a_flr_rsp [`FLR_NUM_PORT]
);

   logic [`FLR_NUM_PORT-1:0] fifo_not_empty;
   logic [`FLR_NUM_PORT-1:0] fifo_pop;
   flr_mux_pkg::flr_msg_t    fifo_rd_data [`FLR_NUM_PORT];

   // ------------------------------
   // Request path
   // ------------------------------
   flr_req_router #(
      .RTABLE (RTABLE)
   ) router_inst (
      .clk       (clk),
      .arst_n    (arst_n),
      .h_flr_req (h_flr_req),
      .a_flr_req (a_flr_req)
   );

   // ------------------------------
   // Response path
   // ------------------------------

   // One buffer per agent, no back-pressure towards the agents
   generate
      for (genvar p = 0; p < `FLR_NUM_PORT; p++) begin : port_gen
         flr_rsp_fifo fifo_inst (
            .clk       (clk),
            .arst_n    (arst_n),
            .wr        (a_flr_rsp[p]),
            .pop       (fifo_pop[p]),
            .not_empty (fifo_not_empty[p]),
            .rd_data   (fifo_rd_data[p])
         );
      end
   endgenerate

   flr_rsp_arbiter arbiter_inst (
      .clk       (clk),
      .arst_n    (arst_n),
      .not_empty (fifo_not_empty),
      .rd_data   (fifo_rd_data),
      .pop       (fifo_pop),
      .h_flr_rsp (h_flr_rsp)
   );

endmodule

// ==== design/flr_mux_pkg.sv ====
// FLR bus types and the default routing table shared by the distributor RTL and its testbench
`include "flr_mux_defines.svh"

package flr_mux_pkg;

   // ------------------------------
   // FLR bus types
   // ------------------------------

   // Function named by a request or a response
   typedef struct packed {
      logic [`FLR_PF_W-1:0] pf;
      logic [`FLR_VF_W-1:0] vf;
      logic                 vf_active;
   } flr_func_t;

   // One strobe on an FLR bus, valid for a single cycle
   typedef struct packed {
      logic      valid;
      flr_func_t func;
   } flr_msg_t;

   // ------------------------------
   // Routing table
   // ------------------------------

   // The any flags turn the field into a wildcard
   // vf_any also ignores vf_active
   typedef struct packed {
      logic [`FLR_PF_W-1:0]   pf;
      logic [`FLR_VF_W-1:0]   vf;
      logic                   vf_active;
      logic                   pf_any;
      logic                   vf_any;
      logic [`FLR_PORT_W-1:0] port;
   } rtable_entry_t;

   typedef rtable_entry_t [`FLR_NUM_RTABLE-1:0] rtable_t;

   // First match wins, so entry 0 is searched first
   // Entry 2 catches every PF0 VF not taken by entry 1
   localparam rtable_t DEFAULT_RTABLE = {
      rtable_entry_t'{pf: 2, vf: 0, vf_active: 1'b0, pf_any: 1'b0, vf_any: 1'b1, port: 3},
      rtable_entry_t'{pf: 1, vf: 0, vf_active: 1'b0, pf_any: 1'b0, vf_any: 1'b1, port: 2},
      rtable_entry_t'{pf: 0, vf: 0, vf_active: 1'b1, pf_any: 1'b0, vf_any: 1'b1, port: 1},
      rtable_entry_t'{pf: 0, vf: 0, vf_active: 1'b1, pf_any: 1'b0, vf_any: 1'b0, port: 1},
      rtable_entry_t'{pf: 0, vf: 0, vf_active: 1'b0, pf_any: 1'b0, vf_any: 1'b0, port: 0}
   };

endpackage

// ==== design/flr_req_router.sv ====
// Host FLR request router, steers each request to the agent port named by the routing table
`timescale 1ns/1ps
`include "flr_mux_defines.svh"

module flr_req_router #(
   parameter flr_mux_pkg::rtable_t RTABLE = flr_mux_pkg::DEFAULT_RTABLE
) (
   input  logic                  clk,
   input  logic                  arst_n,
   input  flr_mux_pkg::flr_msg_t h_flr_req,
   output flr_mux_pkg::flr_msg_t a_flr_req [`FLR_NUM_PORT]
);

   localparam int PORT_W = `FLR_PORT_W;

   logic                  hit;
   logic [PORT_W-1:0]     hit_port;
   logic [`FLR_NUM_PORT-1:0] req_valid;
   flr_mux_pkg::flr_func_t   req_func;

   // Wildcards first, then vf is only compared for an active VF
   function automatic logic entry_match(
      input flr_mux_pkg::flr_func_t     func,
      input flr_mux_pkg::rtable_entry_t entry
   );
      logic pf_ok;
      logic vf_ok;
      pf_ok = entry.pf_any || (func.pf == entry.pf);
      vf_ok = entry.vf_any ||
              ((func.vf_active == entry.vf_active) &&
               (!func.vf_active || (func.vf == entry.vf)));
      return pf_ok && vf_ok;
   endfunction

   // ------------------------------
   // First-match table search
   // ------------------------------
   always_comb begin
      hit      = 1'b0;
      hit_port = '0;
      for (int i = 0; i < `FLR_NUM_RTABLE; i++) begin
         if (!hit && entry_match(h_flr_req.func, RTABLE[i])) begin
            hit      = 1'b1;
            hit_port = RTABLE[i].port;
         end
      end
   end

   // Same payload to all ports, valid only on the matched one
   always_ff @(posedge clk) begin
      req_func <= h_flr_req.func;
   end

   generate
      for (genvar p = 0; p < `FLR_NUM_PORT; p++) begin : port_gen
         always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
               req_valid[p] <= 1'b0;
            end else begin
               req_valid[p] <= h_flr_req.valid && hit && (hit_port == PORT_W'(p));
            end
         end

         assign a_flr_req[p] = '{valid: req_valid[p], func: req_func};
      end
   endgenerate

   // A request for an unmapped function is silently lost
   unmatched_req_a: assert property (
      @(posedge clk) disable iff (!arst_n) h_flr_req.valid |-> hit
   ) else $error("FLR request pf %0d vf %0d matches no routing entry",
                 h_flr_req.func.pf, h_flr_req.func.vf);

endmodule

// ==== design/flr_rsp_arbiter.sv ====
// Round-robin merge of buffered agent FLR responses onto the single host response strobe
`timescale 1ns/1ps
`include "flr_mux_defines.svh"

module flr_rsp_arbiter (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic [`FLR_NUM_PORT-1:0] not_empty,
   input  flr_mux_pkg::flr_msg_t    rd_data [`FLR_NUM_PORT],
   output logic [`FLR_NUM_PORT-1:0] pop,
   output flr_mux_pkg::flr_msg_t    h_flr_rsp
);

   localparam int NUM_PORT = `FLR_NUM_PORT;
   localparam int PORT_W   = `FLR_PORT_W;

   logic [NUM_PORT-1:0] eligible;
   logic                gnt_any;
   logic [PORT_W-1:0]   gnt_idx;
   logic [PORT_W-1:0]   last_gnt;
   logic [PORT_W-1:0]   sel_q;
   logic                rsp_valid;
   flr_mux_pkg::flr_func_t rsp_func;

   // A port whose pop is out this cycle still shows its old count
   assign eligible = not_empty & ~pop;

   // ------------------------------
   // Round-robin grant
   // ------------------------------
   always_comb begin
      int cand;
      gnt_any = 1'b0;
      gnt_idx = '0;
      // Search starts just after the last granted port
      for (int i = 1; i <= NUM_PORT; i++) begin
         cand = (int'(last_gnt) + i) % NUM_PORT;
         if (!gnt_any && eligible[cand]) begin
            gnt_any = 1'b1;
            gnt_idx = PORT_W'(cand);
         end
      end
   end

   // last_gnt doubles as the index of the pop now in flight
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pop      <= '0;
         last_gnt <= PORT_W'(NUM_PORT - 1);
         sel_q    <= '0;
         rsp_valid <= 1'b0;
      end else begin
         pop <= '0;
         if (gnt_any) begin
            pop[gnt_idx] <= 1'b1;
            last_gnt     <= gnt_idx;
         end
         sel_q     <= last_gnt;
         rsp_valid <= rd_data[sel_q].valid;
      end
   end

   // ------------------------------
   // Host response register
   // ------------------------------
   always_ff @(posedge clk) begin
      rsp_func <= rd_data[sel_q].func;
   end

   assign h_flr_rsp = '{valid: rsp_valid, func: rsp_func};

   pop_onehot_a: assert property (
      @(posedge clk) disable iff (!arst_n) $onehot0(pop)
   ) else $error("FLR arbiter popped more than one port");

   // Every pop must come back as read data on the remembered port
   pop_returns_a: assert property (
      @(posedge clk) disable iff (!arst_n) (|pop) |=> rd_data[sel_q].valid
   ) else $error("FLR arbiter pop returned no data on port %0d", sel_q);

endmodule

// ==== design/flr_rsp_fifo.sv ====
// Per-port FLR response buffer, a single-clock FIFO with registered read data
`timescale 1ns/1ps
`include "flr_mux_defines.svh"

module flr_rsp_fifo (
   input  logic                  clk,
   input  logic                  arst_n,
   input  flr_mux_pkg::flr_msg_t wr,
   input  logic                  pop,
   output logic                  not_empty,
   output flr_mux_pkg::flr_msg_t rd_data
);

   localparam int AW    = `FLR_FIFO_DEPTH_LOG2;
   localparam int DEPTH = 1 << AW;

   flr_mux_pkg::flr_func_t mem [DEPTH];

   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          full;
   logic          rd_valid;
   flr_mux_pkg::flr_func_t rd_func;

   assign not_empty = (count != '0);
   assign full      = (count == (AW+1)'(DEPTH));

   // ------------------------------
   // Storage
   // ------------------------------
   always_ff @(posedge clk) begin
      if (wr.valid) begin
         mem[wr_ptr] <= wr.func;
      end
      if (pop) begin
         rd_func <= mem[rd_ptr];
      end
   end

   // ------------------------------
   // Pointers and occupancy
   // ------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         rd_valid <= 1'b0;
      end else begin
         if (wr.valid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         unique case ({wr.valid, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // Read data follows the pop by one cycle
         rd_valid <= pop;
      end
   end

   assign rd_data = '{valid: rd_valid, func: rd_func};

   // Agents may have at most NUM_PORT responses waiting on this port
   no_overflow_a: assert property (
      @(posedge clk) disable iff (!arst_n) wr.valid && full |-> pop
   ) else $error("FLR response FIFO overflow");

   no_underflow_a: assert property (
      @(posedge clk) disable iff (!arst_n) pop |-> not_empty
   ) else $error("FLR response FIFO popped while empty");

endmodule

// ==== include/flr_mux_defines.svh ====
// Build-time sizes for the FLR distributor, included by the package and every RTL module
`ifndef FLR_MUX_DEFINES_SVH
`define FLR_MUX_DEFINES_SVH

// ------------------------------
// Port configuration
// ------------------------------

// Number of agent ports behind the host
`define FLR_NUM_PORT 4

// Port index width, never below one bit
`define FLR_PORT_W ((`FLR_NUM_PORT > 1) ? $clog2(`FLR_NUM_PORT) : 1)

// Each port buffers up to NUM_PORT responses
`define FLR_FIFO_DEPTH_LOG2 `FLR_PORT_W

// ------------------------------
// Routing and function fields
// ------------------------------

`define FLR_NUM_RTABLE 5

// PF and VF number widths of the FLR function word
`define FLR_PF_W 3
`define FLR_VF_W 11

`endif

// ==== tb.f ====
+incdir+include
design/flr_mux_pkg.sv
design/flr_req_router.sv
design/flr_rsp_fifo.sv
design/flr_rsp_arbiter.sv
design/flr_mux.sv
verification/flr_mux_clkgen.sv
verification/flr_mux_tb.sv

// ==== verification/flr_mux_clkgen.sv ====
// Testbench clock and reset source for the FLR distributor, instantiated by the testbench top
`timescale 1ns/1ps

module flr_mux_clkgen #(
   parameter int HALF_PERIOD  = 5,
   parameter int RESET_CYCLES = 2
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   // Release on a falling edge, away from the DUT's sampling edge
   initial begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
   end

endmodule

// ==== verification/flr_mux_tb.sv ====
// Self-checking testbench that drives the FLR distributor as the simulation top
`timescale 1ns/1ps
`include "flr_mux_defines.svh"

module flr_mux_tb;

   localparam int NUM_PORT = `FLR_NUM_PORT;
   localparam int PORT_W   = `FLR_PORT_W;
   localparam int PF_W     = `FLR_PF_W;
   localparam int VF_W     = `FLR_VF_W;

   logic                  clk;
   logic                  arst_n;
   flr_mux_pkg::flr_msg_t h_flr_req;
   flr_mux_pkg::flr_msg_t h_flr_rsp;
   flr_mux_pkg::flr_msg_t a_flr_req [NUM_PORT];
   flr_mux_pkg::flr_msg_t a_flr_rsp [NUM_PORT];

   // Inputs as the DUT took them at the last rising edge
   logic                  rst_done;
   flr_mux_pkg::flr_msg_t req_taken;
   flr_mux_pkg::flr_msg_t rsp_taken [NUM_PORT];

   flr_mux_pkg::flr_msg_t rsp_q [NUM_PORT][$];
   int                    rsp_order [$];
   int                    req_hits [NUM_PORT];
   int                    rsp_sent;
   int                    rsp_seen;
   logic [31:0]           lfsr = 32'h310b2c72;

   flr_mux_clkgen clkgen_inst (
      .clk    (clk),
      .arst_n (arst_n)
   );

   flr_mux flr_mux_inst (
      .clk       (clk),
      .arst_n    (arst_n),
      .h_flr_req (h_flr_req),
      .h_flr_rsp (h_flr_rsp),
      .a_flr_req (a_flr_req),
      .a_flr_rsp (a_flr_rsp)
   );

   // ------------------------------
   // Reference and checks
   // ------------------------------

   // Galois LFSR stepped once per random bit
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
         r[i] = lfsr[0];
      end
      return r;
   endfunction

   // First matching table entry gives the port or -1
   function automatic int ref_route(input flr_mux_pkg::flr_func_t f);
      flr_mux_pkg::rtable_entry_t e;
      for (int i = 0; i < `FLR_NUM_RTABLE; i++) begin
         e = flr_mux_pkg::DEFAULT_RTABLE[i];
         if (!e.pf_any && e.pf != f.pf) continue;
         if (e.vf_any) return int'(e.port);
         if (e.vf_active != f.vf_active) continue;
         if (!f.vf_active || e.vf == f.vf) return int'(e.port);
      end
      return -1;
   endfunction

   // Source port rides in the top VF bits
   function automatic flr_mux_pkg::flr_func_t random_rsp_func(input int port);
      flr_mux_pkg::flr_func_t f;
      f.pf        = PF_W'(random_bits(PF_W));
      f.vf        = VF_W'(random_bits(VF_W));
      f.vf_active = 1'(random_bits(1));
      f.vf[VF_W-1 -: PORT_W] = PORT_W'(port);
      return f;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("SIMULATION FAILED");
      $fatal(1, "%s", why);
   endtask

   task automatic check_req(input int port, input flr_mux_pkg::flr_msg_t exp,
                            input flr_mux_pkg::flr_msg_t act);
      if (act.valid !== exp.valid || (exp.valid && act.func !== exp.func)) begin
         $display("ERROR %0t: a_flr_req[%0d] expected valid %0b func %h, got valid %0b func %h",
                  $time, port, exp.valid, exp.func, act.valid, act.func);
         abort_run("agent request does not match the routing table");
      end
   endtask

   task automatic check_rsp(input flr_mux_pkg::flr_msg_t exp,
                            input flr_mux_pkg::flr_msg_t act);
      if (act !== exp) begin
         $display("ERROR %0t: h_flr_rsp expected func %h, got valid %0b func %h",
                  $time, exp.func, act.valid, act.func);
         abort_run("host response out of order or corrupted");
      end
   endtask

   task automatic check_grant(input logic [PORT_W-1:0] exp, input logic [PORT_W-1:0] act);
      if (act !== exp) begin
         $display("ERROR %0t: response from port %0d, round-robin expects port %0d",
                  $time, act, exp);
         abort_run("arbiter broke round-robin order");
      end
   endtask

   always @(posedge clk) begin
      rst_done  <= arst_n;
      req_taken <= h_flr_req;
      for (int p = 0; p < NUM_PORT; p++) begin
         rsp_taken[p] <= a_flr_rsp[p];
      end
   end

   // Compare at the falling edge where every DUT output is stable
   always @(negedge clk) begin
      int                    route;
      int                    port;
      flr_mux_pkg::flr_msg_t exp;
      if (rst_done) begin
         route = req_taken.valid ? ref_route(req_taken.func) : -1;
         if (route >= 0) begin
            req_hits[route]++;
         end
         for (int p = 0; p < NUM_PORT; p++) begin
            exp = '{valid: (route == p), func: req_taken.func};
            check_req(p, exp, a_flr_req[p]);
            if (rsp_taken[p].valid) begin
               rsp_q[p].push_back(rsp_taken[p]);
               rsp_sent++;
            end
         end
         if (h_flr_rsp.valid) begin
            port = int'(h_flr_rsp.func.vf[VF_W-1 -: PORT_W]);
            if (port >= NUM_PORT || rsp_q[port].size() == 0) begin
               abort_run("host response arrived that no agent sent");
            end
            exp = rsp_q[port].pop_front();
            check_rsp(exp, h_flr_rsp);
            rsp_order.push_back(port);
            rsp_seen++;
         end
      end
   end

   // ------------------------------
   // Stimulus
   // ------------------------------
   task automatic drive_idle();
      @(negedge clk);
      h_flr_req = '0;
      for (int p = 0; p < NUM_PORT; p++) begin
         a_flr_rsp[p] = '0;
      end
   endtask

   task automatic send_req(input flr_mux_pkg::flr_func_t f);
      drive_idle();
      h_flr_req = '{valid: 1'b1, func: f};
   endtask

   task automatic send_rsps(input logic [NUM_PORT-1:0] mask);
      drive_idle();
      for (int p = 0; p < NUM_PORT; p++) begin
         if (mask[p]) begin
            a_flr_rsp[p] = '{valid: 1'b1, func: random_rsp_func(p)};
         end
      end
   endtask

   task automatic wait_drain(input int max_cycles);
      int cycles;
      drive_idle();
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
         if (cycles > max_cycles) begin
            abort_run("timed out waiting for host responses");
         end
      end while (rsp_seen != rsp_sent);
   endtask

   initial begin
      flr_mux_pkg::flr_func_t f;
      logic [NUM_PORT-1:0]    mask;
      int                     cycles;
      int                     start;
      int                     base;
      h_flr_req = '0;
      for (int p = 0; p < NUM_PORT; p++) begin
         a_flr_rsp[p] = '0;
      end
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
         if (cycles > 20) begin
            abort_run("reset was never released");
         end
      end while (!arst_n);

      // Quiet outputs after reset
      repeat (10) drive_idle();

      // Routing of mapped PFs
      for (int n = 0; n < 200; n++) begin
         f.pf        = PF_W'(random_bits(2) % 3);
         f.vf        = VF_W'(random_bits(VF_W));
         f.vf_active = 1'(random_bits(1));
         send_req(f);
      end
      repeat (2) drive_idle();
      @(posedge clk);
      for (int p = 0; p < NUM_PORT; p++) begin
         if (req_hits[p] == 0) begin
            abort_run("an agent port never received a routed request");
         end
      end

      // Unmapped PFs are dropped
      $assertoff;
      for (int n = 0; n < 20; n++) begin
         f.pf        = PF_W'(3 + random_bits(3) % 5);
         f.vf        = VF_W'(random_bits(VF_W));
         f.vf_active = 1'(random_bits(1));
         send_req(f);
      end
      repeat (2) drive_idle();
      $asserton;

      for (int n = 0; n < 8; n++) begin
         send_rsps(NUM_PORT'(1) << (random_bits(PORT_W) % NUM_PORT));
         wait_drain(20);
      end

      // All ports at once after a single response sets the pointer
      for (int n = 0; n < 4; n++) begin
         start = int'(random_bits(PORT_W) % NUM_PORT);
         send_rsps(NUM_PORT'(1) << start);
         wait_drain(20);
         base  = rsp_order.size();
         send_rsps('1);
         wait_drain(40);
         for (int i = 0; i < NUM_PORT; i++) begin
            check_grant(PORT_W'((start + 1 + i) % NUM_PORT), PORT_W'(rsp_order[base + i]));
         end
      end

      // Fill each port in turn against random traffic on the others
      for (int fill = 0; fill < NUM_PORT; fill++) begin
         for (int n = 0; n < NUM_PORT; n++) begin
            mask = NUM_PORT'(random_bits(NUM_PORT)) | (NUM_PORT'(1) << fill);
            send_rsps(mask);
         end
         wait_drain(100);
      end

      if (rsp_seen == rsp_sent && rsp_seen > 0) begin
         $display("SIMULATION PASSED");
         $finish;
      end else begin
         abort_run("responses were lost or none were sent");
      end
   end

endmodule
